//--- all.f
common/mtx_pkg.sv
tx/frame_fifo.sv
tx/bpsk_mapper.sv
hdl/symbol_timer.sv
hdl/mtx_fsm.sv
hdl/mtx_core.sv
test/mtx_core_properties.sv
test/mtx_core_tb.sv

//--- Makefile
SIM  := obj_dir/Vmtx_core_tb
SRCS := $(wildcard common/*.sv hdl/*.sv tx/*.sv test/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) all.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module mtx_core_tb -f all.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; test $$status -eq 0
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/mtx_core_tb.sv
module mtx_core_tb import mtx_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD     = 40;
   localparam int DRIVE_DELAY    = 2;
   localparam int RESET_CYCLES   = 8;
   localparam int NUM_FRAMES     = 6;
   localparam int NUM_WORDS      = NUM_FRAMES * FRAME_WORDS;
   localparam int FRAME_SAMPLES  = FRAME_BITS * SAMPLES_PER_BIT;
   localparam int GAP_CYCLES     = 1;    // one dead DAC cycle between buffered frames
   localparam int CREDIT_TIMEOUT = 2 * FRAME_SAMPLES;
   localparam int DRAIN_TIMEOUT  = (NUM_FRAMES + 1) * (FRAME_SAMPLES + 8);
   localparam int RETURN_TIMEOUT = 16;

   logic  radio_clk;
   logic  i_reset;
   logic  i_word_valid;
   word_t i_word;
   logic  o_credit;
   logic  o_tx_valid;
   word_t o_tx_sample;
   logic  o_ptt;

   // stimulus table with one row per frame
   word_t frame_words [NUM_FRAMES][FRAME_WORDS];

   integer seed;
   int     words_sent       = 0;    // host side
   int     credits_returned = 0;    // monitor side
   int     frames_done      = 0;

   mtx_core UUT (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_word_valid(i_word_valid),
      .i_word      (i_word),
      .o_credit    (o_credit),
      .o_tx_valid  (o_tx_valid),
      .o_tx_sample (o_tx_sample),
      .o_ptt       (o_ptt)
   );

   initial begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
   end

   // ------------------------------
   // helpers
   // ------------------------------
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         stop_on_error($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                 $time, name, got, expected));
      end
   endtask

   task automatic load_table();
      int f;
      int w;
      seed           = 32'h55f6_5db6;
      frame_words[0] = '{default: 32'hFFFF_FFFF};
      frame_words[1] = '{default: 32'h0000_0000};
      frame_words[2] = '{default: 32'hAAAA_5555};
      frame_words[3] = '{32'h0, 32'h0, 32'h0000_0100, 32'h0};
      for (f = 4; f < NUM_FRAMES; f++) begin
         for (w = 0; w < FRAME_WORDS; w++) begin
            frame_words[f][w] = $random(seed);
         end
      end
   endtask

   // bpsk mapping of the table bits msb first
   function automatic word_t expected_sample(input int frame, input int idx);
      sample_u s;
      int      bit_idx;
      word_t   w;
      bit_idx = idx / SAMPLES_PER_BIT;
      w       = frame_words[frame][bit_idx / WORD_W];
      s.iq.i  = w[WORD_W - 1 - (bit_idx % WORD_W)] ? IQ_W'(AMPLITUDE) : IQ_W'(-AMPLITUDE);
      s.iq.q  = '0;
      return s.raw;
   endfunction

   // host model spending one credit per word
   task automatic send_words();
      int idx;
      int waited;
      for (idx = 0; idx < NUM_WORDS; idx++) begin
         waited = 0;
         while (words_sent - credits_returned >= FIFO_DEPTH) begin
            i_word_valid = 1'b0;
            @(posedge radio_clk);
            #DRIVE_DELAY;
            waited++;
            if (waited > CREDIT_TIMEOUT) begin
               stop_on_error("no credit came back while the host still had words to send");
            end
         end
         i_word_valid = 1'b1;
         i_word       = frame_words[idx / FRAME_WORDS][idx % FRAME_WORDS];
         words_sent++;
         @(posedge radio_clk);
         #DRIVE_DELAY;
      end
      i_word_valid = 1'b0;
   endtask

   // ------------------------------
   // monitor
   // ------------------------------
   initial begin : monitor
      int run_len;
      int gap_len;
      run_len = 0;
      gap_len = 0;
      forever begin
         @(negedge radio_clk);
         check_value("o_ptt", 32'(o_ptt), 32'(o_tx_valid));
         if (i_reset) begin
            check_value("o_tx_valid", 32'(o_tx_valid), 32'd0);
            check_value("o_credit", 32'(o_credit), 32'd0);
            check_value("o_tx_sample", o_tx_sample, 32'd0);
         end else begin
            if (o_credit) begin
               credits_returned++;
               if (credits_returned > words_sent) begin
                  stop_on_error("a credit came back for a word that was never written");
               end
            end
            if (o_tx_valid) begin
               if (run_len == 0) begin
                  if (frames_done >= NUM_FRAMES) begin
                     stop_on_error("samples appeared after the last frame");
                  end
                  if (words_sent < (frames_done + 1) * FRAME_WORDS) begin
                     stop_on_error("a frame started before all its words were written");
                  end
                  if (frames_done > 0) check_value("gap cycles", gap_len, GAP_CYCLES);
               end
               if (run_len >= FRAME_SAMPLES) begin
                  stop_on_error("o_tx_valid stayed high past the end of a frame");
               end
               check_value("o_tx_sample", o_tx_sample, expected_sample(frames_done, run_len));
               run_len++;
            end else begin
               if (run_len > 0) begin    // frame just ended
                  check_value("frame length", run_len, FRAME_SAMPLES);
                  frames_done++;
                  run_len = 0;
                  gap_len = 0;
               end
               gap_len++;
               check_value("o_tx_sample", o_tx_sample, 32'd0);   // DAC parked at zero
            end
         end
      end
   end

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin : main
      int waited;
      i_reset      = 1'b1;
      i_word_valid = 1'b0;
      i_word       = '0;
      load_table();
      repeat (RESET_CYCLES) @(posedge radio_clk);
      #DRIVE_DELAY;
      i_reset = 1'b0;

      send_words();

      waited = 0;
      while (frames_done < NUM_FRAMES) begin
         @(posedge radio_clk);
         waited++;
         if (waited > DRAIN_TIMEOUT) begin
            stop_on_error($sformatf("only %0d of %0d frames were sent", frames_done, NUM_FRAMES));
         end
      end

      waited = 0;
      while (credits_returned < words_sent) begin
         @(posedge radio_clk);
         waited++;
         if (waited > RETURN_TIMEOUT) begin
            stop_on_error("not all credits came back after the last frame");
         end
      end

      $display("Test passed");
      $finish;
   end

endmodule

//--- test/mtx_core_properties.sv
module mtx_core_properties import mtx_pkg::*; (
   input logic               radio_clk,
   input logic               i_reset,
   input logic               i_word_valid,
   input logic [LEVEL_W-1:0] i_level,
   input logic               i_tx_valid,
   input logic               i_ptt
);

   timeunit 1ns;
   timeprecision 1ps;

   // keying line follows the sample strobe
   ptt_follows_valid: assert property (
      @(posedge radio_clk) disable iff (i_reset) i_ptt == i_tx_valid
   ) else $error("o_ptt differs from o_tx_valid");

   // a push spends a credit, so never into a full buffer
   no_push_when_full: assert property (
      @(posedge radio_clk) disable iff (i_reset)
         !(i_word_valid && (i_level == LEVEL_W'(FIFO_DEPTH)))
   ) else $error("word pushed into a full buffer");

   quiet_in_reset: assert property (
      @(posedge radio_clk) i_reset |=> !i_tx_valid
   ) else $error("o_tx_valid high while reset is held");

endmodule

bind mtx_core mtx_core_properties properties_i (
   .radio_clk   (radio_clk),
   .i_reset     (i_reset),
   .i_word_valid(i_word_valid),
   .i_level     (level),
   .i_tx_valid  (o_tx_valid),
   .i_ptt       (o_ptt)
);

//--- hdl/mtx_core.sv
module mtx_core import mtx_pkg::*; (
   input  logic  radio_clk,
   input  logic  i_reset,

   // host side, credit based
   input  logic  i_word_valid,
   input  word_t i_word,
   output logic  o_credit,

   // DAC side, no back-pressure
   output logic  o_tx_valid,
   output word_t o_tx_sample,
   output logic  o_ptt
);

   word_t              head_word;
   logic [LEVEL_W-1:0] level;

   logic pop;
   logic load;
   logic shift;
   logic start;
   logic active;

   logic bit_end;
   logic word_end;
   logic frame_end;

   // ------------------------------
   // host words into the buffer
   // ------------------------------
   frame_fifo frame_fifo_i (
      .radio_clk (radio_clk),
      .i_reset   (i_reset),
      .i_push    (i_word_valid),
      .i_word    (i_word),
      .i_pop     (pop),
      .o_head    (head_word),
      .o_level   (level),
      .o_credit  (o_credit)
   );

   mtx_fsm mtx_fsm_i (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_level     (level),
      .i_bit_end   (bit_end),
      .i_word_end  (word_end),
      .i_frame_end (frame_end),
      .o_pop       (pop),
      .o_load      (load),
      .o_shift     (shift),
      .o_start     (start),
      .o_active    (active)
   );

   // counts the samples actually leaving for the DAC
   symbol_timer symbol_timer_i (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_start     (start),
      .i_run       (o_tx_valid),
      .o_bit_end   (bit_end),
      .o_word_end  (word_end),
      .o_frame_end (frame_end)
   );

   bpsk_mapper bpsk_mapper_i (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_load      (load),
      .i_shift     (shift),
      .i_word      (head_word),
      .i_active    (active),
      .o_tx_valid  (o_tx_valid),
      .o_tx_sample (o_tx_sample),
      .o_ptt       (o_ptt)
   );

endmodule

//--- hdl/mtx_fsm.sv
module mtx_fsm import mtx_pkg::*; (
   input  logic               radio_clk,
   input  logic               i_reset,
   input  logic [LEVEL_W-1:0] i_level,
   input  logic               i_bit_end,
   input  logic               i_word_end,
   input  logic               i_frame_end,
   output logic               o_pop,
   output logic               o_load,
   output logic               o_shift,
   output logic               o_start,
   output logic               o_active
);

   logic [STATE_W-1:0] state;
   logic [STATE_W-1:0] state_nxt;

   logic frame_ready;
   logic frame_go;     // first word of a frame
   logic next_word;    // words 2 to 4

   assign frame_ready = (i_level >= LEVEL_W'(FRAME_WORDS));
   assign frame_go    = ((state == ST_IDLE) || (state == ST_GAP)) && frame_ready;

   // no reload after the last word of the frame
   assign next_word = (state == ST_SEND) && i_word_end && !i_frame_end;

   // ------------------------------
   // next state
   // ------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (frame_ready) begin
               state_nxt = ST_SEND;
            end
         end
         ST_SEND: begin
            if (i_frame_end) begin
               state_nxt = ST_GAP;
            end
         end
         ST_GAP: begin
            // next frame may load during the dead DAC cycle
            if (frame_ready) begin
               state_nxt = ST_SEND;
            end else begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // ------------------------------
   // strobes to buffer, timer, mapper
   // ------------------------------
   assign o_pop   = frame_go || next_word;
   assign o_load  = frame_go || next_word;   // head word is valid in the same cycle
   assign o_start = frame_go;

   // word boundaries reload instead of shifting
   assign o_shift = (state == ST_SEND) && i_bit_end && !i_word_end;

   // registered by the mapper, so it leads the DAC samples by one cycle
   assign o_active = frame_go || ((state == ST_SEND) && !i_frame_end);

endmodule

//--- hdl/symbol_timer.sv
module symbol_timer import mtx_pkg::*; (
   input  logic radio_clk,
   input  logic i_reset,
   input  logic i_start,
   input  logic i_run,         // one per sample sent
   output logic o_bit_end,
   output logic o_word_end,
   output logic o_frame_end
);

   logic [SAMPLE_CNT_W-1:0] sample_cnt;
   logic [BIT_CNT_W-1:0]    bit_cnt;
   logic [WORD_CNT_W-1:0]   word_cnt;

   logic last_sample;
   logic last_bit;
   logic last_word;

   assign last_sample = (sample_cnt == SAMPLE_CNT_W'(SAMPLES_PER_BIT - 1));
   assign last_bit    = (bit_cnt == BIT_CNT_W'(WORD_W - 1));
   assign last_word   = (word_cnt == WORD_CNT_W'(FRAME_WORDS - 1));

   // events only in cycles that carry a sample
   assign o_bit_end   = i_run && last_sample;
   assign o_word_end  = o_bit_end && last_bit;
   assign o_frame_end = o_word_end && last_word;

   always_ff @(posedge radio_clk) begin
      if (i_reset || i_start) begin
         sample_cnt <= '0;
         bit_cnt    <= '0;
         word_cnt   <= '0;
      end else if (i_run) begin
         sample_cnt <= last_sample ? '0 : sample_cnt + 1'b1;
         if (o_bit_end) begin
            bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
         end
         if (o_word_end) begin
            word_cnt <= last_word ? '0 : word_cnt + 1'b1;   // wraps at frame end
         end
      end
   end

endmodule

//--- tx/bpsk_mapper.sv
module bpsk_mapper import mtx_pkg::*; (
   input  logic  radio_clk,
   input  logic  i_reset,
   input  logic  i_load,
   input  logic  i_shift,
   input  word_t i_word,
   input  logic  i_active,
   output logic  o_tx_valid,
   output word_t o_tx_sample,
   output logic  o_ptt
);

   word_t   shreg;
   word_t   shreg_nxt;
   sample_u mapped;
   sample_u sample_q;
   logic    valid_q;
   logic    ptt_q;

   // ------------------------------
   // bit source, msb first
   // ------------------------------
   always_comb begin
      if (i_load) begin
         shreg_nxt = i_word;
      end else if (i_shift) begin
         shreg_nxt = {shreg[WORD_W-2:0], 1'b0};
      end else begin
         shreg_nxt = shreg;
      end
   end

   always_ff @(posedge radio_clk) begin
      shreg <= shreg_nxt;
   end

   // mapped from the incoming register value so the new bit shows next cycle
   always_comb begin
      if (shreg_nxt[WORD_W-1]) begin
         mapped.iq.i = IQ_W'(AMPLITUDE);
      end else begin
         mapped.iq.i = IQ_W'(-AMPLITUDE);
      end
      mapped.iq.q = '0;   // bpsk, real axis only
   end

   // ------------------------------
   // output register
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         sample_q <= '0;
         valid_q  <= 1'b0;
         ptt_q    <= 1'b0;
      end else begin
         sample_q <= i_active ? mapped : '0;   // DAC sits at zero when idle
         valid_q  <= i_active;
         ptt_q    <= i_active;                 // keying line
      end
   end

   assign o_tx_valid  = valid_q;
   assign o_tx_sample = sample_q.raw;
   assign o_ptt       = ptt_q;

endmodule

//--- tx/frame_fifo.sv
module frame_fifo import mtx_pkg::*; (
   input  logic               radio_clk,
   input  logic               i_reset,
   input  logic               i_push,
   input  word_t              i_word,
   input  logic               i_pop,
   output word_t              o_head,
   output logic [LEVEL_W-1:0] o_level,
   output logic               o_credit
);

   word_t mem [FIFO_DEPTH];

   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [LEVEL_W-1:0] level;

   logic full;
   logic empty;
   logic do_push;
   logic do_pop;

   assign full  = (level == LEVEL_W'(FIFO_DEPTH));
   assign empty = (level == '0);

   assign do_push = i_push && !full;    // host holds no credit when full
   assign do_pop  = i_pop && !empty;

   // ------------------------------
   // storage
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_word;
      end
   end

   assign o_head  = mem[rd_ptr];        // fall-through, no read latency
   assign o_level = level;

   // ------------------------------
   // pointers, level, credit
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         level    <= '0;
         o_credit <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;      // both or neither
         endcase
         o_credit <= do_pop;              // one credit back per word out
      end
   end

endmodule

//--- common/mtx_pkg.sv
package mtx_pkg;

   // ------------------------------
   // frame geometry
   // ------------------------------
   localparam int WORD_W      = 32;
   localparam int FRAME_WORDS = 4;
   localparam int FRAME_BITS  = FRAME_WORDS * WORD_W;    // 128 bits per frame

   // word buffer, level counts 0..FIFO_DEPTH
   localparam int FIFO_DEPTH = 8;
   localparam int PTR_W      = $clog2(FIFO_DEPTH);
   localparam int LEVEL_W    = $clog2(FIFO_DEPTH + 1);

   // ------------------------------
   // symbol timing and levels
   // ------------------------------
   localparam int SAMPLES_PER_BIT = 8;
   localparam int SAMPLE_CNT_W    = $clog2(SAMPLES_PER_BIT);
   localparam int BIT_CNT_W       = $clog2(WORD_W);
   localparam int WORD_CNT_W      = $clog2(FRAME_WORDS);

   localparam int IQ_W      = WORD_W / 2;
   localparam int AMPLITUDE = 8192;                     // full scale is 32767

   // frame FSM encoding
   localparam int STATE_W = 2;
   localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
   localparam logic [STATE_W-1:0] ST_SEND = 2'd1;
   localparam logic [STATE_W-1:0] ST_GAP  = 2'd2;

   typedef logic [WORD_W-1:0] word_t;

   // I in the upper half, Q in the lower, as the DAC expects
   typedef struct packed {
      logic signed [IQ_W-1:0] i;
      logic signed [IQ_W-1:0] q;
   } iq_t;

   typedef union packed {
      word_t raw;
      iq_t   iq;
   } sample_u;

endpackage
